// File: Bender.yml
package:
  name: sync_fifo_ctrl

export_include_dirs:
  - .

sources:
  - sync_fifo_ctrl_pkg.sv
  - fifo_level_ctrl.sv
  - fifo_mem_addr.sv
  - fifo_access_status.sv
  - sync_fifo_ctrl.sv
  - target: test
    files:
      - sync_fifo_ctrl_sva.sv
      - tb_sync_fifo_ctrl.sv

// File: fifo_access_status.sv
// Registered write-acknowledge, data-valid, overflow and underflow pulses for each FIFO access

`default_nettype none

`include "sync_fifo_ctrl_defs.svh"

module fifo_access_status #(
   parameter int unsigned DVLD_LAT = `SFC_DVLD_LAT   // Read-to-dvld cycles, 1 or 2
) (
   input  wire logic pos_clk,
   input  wire logic aresetn,
   input  wire logic we_i,        // Raw write request
   input  wire logic re_i,        // Raw read request
   input  wire logic wr_acc_i,    // Write taken
   input  wire logic rd_acc_i,    // Read taken
   input  wire logic full_i,      // Current full flag
   input  wire logic empty_i,     // Current empty flag
   output logic      wack_o,
   output logic      dvld_o,
   output logic      overflow_o,
   output logic      underflow_o
);

   logic                wack_r;
   logic                ovf_r;
   logic                udf_r;
   logic [DVLD_LAT-1:0] dvld_pipe;  // One bit per read in flight

   // Only the one and two stage options exist on the memory side
   if ((DVLD_LAT < 1) || (DVLD_LAT > 2)) begin : g_bad_lat
      $error("fifo_access_status: DVLD_LAT must be 1 or 2");
   end

   // ----------------------------------------------------------
   // Access pulses
   // ----------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_r <= 1'b0;
         ovf_r  <= 1'b0;
         udf_r  <= 1'b0;
      end else begin
         wack_r <= wr_acc_i;            // Write went into memory
         ovf_r  <= we_i & full_i;       // Write refused
         udf_r  <= re_i & empty_i;      // Read refused
      end
   end

   // ----------------------------------------------------------
   // Data-valid delay line
   // ----------------------------------------------------------
   // Back-to-back reads each carry their own bit down the line
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_pipe <= '0;
      end else begin
         dvld_pipe[0] <= rd_acc_i;
         for (int i = 1; i < DVLD_LAT; i++) begin
            dvld_pipe[i] <= dvld_pipe[i-1];   // Shift toward the output
         end
      end
   end

   assign wack_o      = wack_r;
   assign dvld_o      = dvld_pipe[DVLD_LAT-1];  // Last stage
   assign overflow_o  = ovf_r;
   assign underflow_o = udf_r;

endmodule

`default_nettype wire

// File: fifo_level_ctrl.sv
// Occupancy counter with write/read accept gating and the registered empty/full level flags

`default_nettype none

`include "sync_fifo_ctrl_defs.svh"

module fifo_level_ctrl (
   input  wire logic                     pos_clk,
   input  wire logic                     aresetn,
   input  wire logic                     we_i,      // Raw write request
   input  wire logic                     re_i,      // Raw read request
   output logic                          wr_acc_o,  // Write taken this cycle
   output logic                          rd_acc_o,  // Read taken this cycle
   output sync_fifo_ctrl_pkg::occ_t      count_o,   // Entries held
   output logic                          empty_o,
   output logic                          aempty_o,
   output logic                          full_o,
   output logic                          afull_o
);

   // ----------------------------------------------------------
   // Thresholds in counter width
   // ----------------------------------------------------------
   localparam sync_fifo_ctrl_pkg::occ_t FULL_LVL   =
      sync_fifo_ctrl_pkg::occ_t'(`SFC_DEPTH);
   localparam sync_fifo_ctrl_pkg::occ_t AFULL_LVL  =
      sync_fifo_ctrl_pkg::occ_t'(`SFC_AFULL_VAL);
   localparam sync_fifo_ctrl_pkg::occ_t AEMPTY_LVL =
      sync_fifo_ctrl_pkg::occ_t'(`SFC_AEMPTY_VAL);
   localparam sync_fifo_ctrl_pkg::occ_t ONE        =
      sync_fifo_ctrl_pkg::occ_t'(1);

   sync_fifo_ctrl_pkg::occ_t count_r;   // Up/down counter
   sync_fifo_ctrl_pkg::occ_t count_nxt; // Level after this edge
   logic                     empty_r;
   logic                     aempty_r;
   logic                     full_r;
   logic                     afull_r;
   logic                     wr_acc;
   logic                     rd_acc;

   // ----------------------------------------------------------
   // Accept gating
   // ----------------------------------------------------------
   // Flags are registered, so no path from count back to the strobes
   assign wr_acc = we_i & ~full_r;     // Drop writes when full
   assign rd_acc = re_i & ~empty_r;    // Drop reads when empty

   // ----------------------------------------------------------
   // Next occupancy
   // ----------------------------------------------------------
   always_comb begin
      count_nxt = count_r;              // Both or neither: hold
      case ({wr_acc, rd_acc})
         2'b10:   count_nxt = count_r + ONE;
         2'b01:   count_nxt = count_r - ONE;
         default: count_nxt = count_r;
      endcase
   end

   // ----------------------------------------------------------
   // Counter and level flags
   // ----------------------------------------------------------
   // All four flags come from count_nxt, so they switch
   // on the same edge as the counter itself
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_r  <= '0;
         empty_r  <= 1'b1;              // Nothing stored after reset
         aempty_r <= 1'b1;
         full_r   <= 1'b0;
         afull_r  <= 1'b0;
      end else begin
         count_r  <= count_nxt;
         empty_r  <= (count_nxt == '0);
         aempty_r <= (count_nxt <= AEMPTY_LVL);
         full_r   <= (count_nxt == FULL_LVL);
         afull_r  <= (count_nxt >= AFULL_LVL);
      end
   end

   // ----------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------
   assign wr_acc_o = wr_acc;           // To pointers and status
   assign rd_acc_o = rd_acc;
   assign count_o  = count_r;
   assign empty_o  = empty_r;
   assign aempty_o = aempty_r;
   assign full_o   = full_r;
   assign afull_o  = afull_r;

endmodule

`default_nettype wire

// File: fifo_mem_addr.sv
// Wrapping write and read pointers plus the enables presented to the external FIFO memory

`default_nettype none

module fifo_mem_addr (
   input  wire logic                     pos_clk,
   input  wire logic                     aresetn,
   input  wire logic                     wr_acc_i,    // Accepted write
   input  wire logic                     rd_acc_i,    // Accepted read
   output logic                          mem_we_o,
   output logic                          mem_re_o,
   output sync_fifo_ctrl_pkg::addr_t     mem_waddr_o,
   output sync_fifo_ctrl_pkg::addr_t     mem_raddr_o
);

   localparam sync_fifo_ctrl_pkg::addr_t ADDR_ONE = sync_fifo_ctrl_pkg::addr_t'(1);

   sync_fifo_ctrl_pkg::addr_t waddr_r;
   sync_fifo_ctrl_pkg::addr_t raddr_r;

   // ----------------------------------------------------------
   // Pointers
   // ----------------------------------------------------------
   // Depth is a power of two, natural overflow wraps to 0
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_r <= '0;
         raddr_r <= '0;
      end else begin
         if (wr_acc_i) begin
            waddr_r <= waddr_r + ADDR_ONE;   // Step past the word just written
         end
         if (rd_acc_i) begin
            raddr_r <= raddr_r + ADDR_ONE;   // Step past the word just read
         end
      end
   end

   // ----------------------------------------------------------
   // Memory side
   // ----------------------------------------------------------
   // Enables are the accepted strobes of this same cycle, and the
   // address shown during the enable is the one the memory uses
   assign mem_we_o    = wr_acc_i;
   assign mem_re_o    = rd_acc_i;
   assign mem_waddr_o = waddr_r;
   assign mem_raddr_o = raddr_r;

endmodule

`default_nettype wire

// File: sync_fifo_ctrl.f
+incdir+.
sync_fifo_ctrl_pkg.sv
fifo_level_ctrl.sv
fifo_mem_addr.sv
fifo_access_status.sv
sync_fifo_ctrl.sv
sync_fifo_ctrl_sva.sv
tb_sync_fifo_ctrl.sv

// File: sync_fifo_ctrl.sv
// Top level of the synchronous FIFO controller, drives an external memory from write/read strobes

`default_nettype none

module sync_fifo_ctrl (
   input  wire logic                     pos_clk,
   input  wire logic                     aresetn,
   input  wire logic                     we_i,
   input  wire logic                     re_i,
   output sync_fifo_ctrl_pkg::occ_t      count_o,
   output logic                          empty_o,
   output logic                          aempty_o,
   output logic                          full_o,
   output logic                          afull_o,
   output logic                          mem_we_o,
   output logic                          mem_re_o,
   output sync_fifo_ctrl_pkg::addr_t     mem_waddr_o,
   output sync_fifo_ctrl_pkg::addr_t     mem_raddr_o,
   output logic                          wack_o,
   output logic                          dvld_o,
   output logic                          overflow_o,
   output logic                          underflow_o
);

   logic wr_acc;   // Accepted write, from the level block
   logic rd_acc;   // Accepted read

   // ----------------------------------------------------------
   // Occupancy and flags
   // ----------------------------------------------------------
   fifo_level_ctrl i_level (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .we_i     (we_i),
      .re_i     (re_i),
      .wr_acc_o (wr_acc),
      .rd_acc_o (rd_acc),
      .count_o  (count_o),
      .empty_o  (empty_o),
      .aempty_o (aempty_o),
      .full_o   (full_o),
      .afull_o  (afull_o)
   );

   // Memory pointers and enables
   fifo_mem_addr i_addr (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_acc_i    (wr_acc),
      .rd_acc_i    (rd_acc),
      .mem_we_o    (mem_we_o),
      .mem_re_o    (mem_re_o),
      .mem_waddr_o (mem_waddr_o),
      .mem_raddr_o (mem_raddr_o)
   );

   // Pulses, error checks use the registered flags
   fifo_access_status i_status (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .wr_acc_i    (wr_acc),
      .rd_acc_i    (rd_acc),
      .full_i      (full_o),
      .empty_i     (empty_o),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

endmodule

`default_nettype wire

// File: sync_fifo_ctrl_defs.svh
// Sizing and threshold constants for the FIFO controller, included by the RTL and the testbench

`ifndef SYNC_FIFO_CTRL_DEFS_SVH
`define SYNC_FIFO_CTRL_DEFS_SVH

// ----------------------------------------------------------
// Memory geometry
// ----------------------------------------------------------
`define SFC_ADDR_W      4        // Address bits of the external memory
`define SFC_DEPTH       16       // Entries, 2**SFC_ADDR_W

// ----------------------------------------------------------
// Level thresholds
// ----------------------------------------------------------
`define SFC_AFULL_VAL   12       // afull at or above this level
`define SFC_AEMPTY_VAL  4        // aempty at or below this level

// ----------------------------------------------------------
// Read data timing
// ----------------------------------------------------------
`define SFC_DVLD_LAT    1        // Cycles from accepted read to dvld, 1 or 2

`endif

// File: sync_fifo_ctrl_pkg.sv
// Shared occupancy and address types, referenced as sync_fifo_ctrl_pkg::name by the FIFO blocks

`default_nettype none

`include "sync_fifo_ctrl_defs.svh"

package sync_fifo_ctrl_pkg;

   // ----------------------------------------------------------
   // Types
   // ----------------------------------------------------------

   // One extra bit so that a full FIFO (SFC_DEPTH) is representable
   typedef logic [`SFC_ADDR_W:0] occ_t;

   // Memory word address, wraps modulo SFC_DEPTH
   typedef logic [`SFC_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// File: sync_fifo_ctrl_sva.sv
// Concurrent assertions on the FIFO controller top level, attached by the bind at the end

`default_nettype none

`include "sync_fifo_ctrl_defs.svh"

module sync_fifo_ctrl_sva (
   input wire logic                      pos_clk,
   input wire logic                      aresetn,
   input wire sync_fifo_ctrl_pkg::occ_t  count_o,
   input wire logic                      empty_o,
   input wire logic                      full_o,
   input wire logic                      mem_we_o,
   input wire logic                      mem_re_o,
   input wire logic                      dvld_o
);

   // ----------------------------------------------------------
   // Level consistency
   // ----------------------------------------------------------
   a_not_empty_and_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(empty_o && full_o)) else $error("empty and full high together");

   a_count_in_range: assert property (@(posedge pos_clk) disable iff (!aresetn)
      count_o <= `SFC_DEPTH) else $error("count above depth");

   // Memory enables stay off at the boundaries
   a_no_write_when_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(mem_we_o && full_o)) else $error("memory write while full");

   a_no_read_when_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(mem_re_o && empty_o)) else $error("memory read while empty");

   // ----------------------------------------------------------
   // Read data timing
   // ----------------------------------------------------------
   a_dvld_follows_read: assert property (@(posedge pos_clk) disable iff (!aresetn)
      dvld_o == $past(mem_re_o, `SFC_DVLD_LAT)) else $error("dvld does not track reads");

endmodule

bind sync_fifo_ctrl sync_fifo_ctrl_sva i_sva (
   .pos_clk  (pos_clk),
   .aresetn  (aresetn),
   .count_o  (count_o),
   .empty_o  (empty_o),
   .full_o   (full_o),
   .mem_we_o (mem_we_o),
   .mem_re_o (mem_re_o),
   .dvld_o   (dvld_o)
);

`default_nettype wire

// File: tb_sync_fifo_ctrl.sv
// Self-checking testbench for sync_fifo_ctrl, run as top module tb_sync_fifo_ctrl with the SVA bind

`default_nettype none

`include "sync_fifo_ctrl_defs.svh"

module tb_sync_fifo_ctrl;

   localparam int FILL_N  = 20;     // Writes from empty
   localparam int DRAIN_N = 20;     // Reads from full
   localparam int MID_W   = 8;      // Level for the mixed phase
   localparam int MID_N   = 20;     // Simultaneous read+write cycles
   localparam int RAND_N  = 2000;   // Random traffic cycles
   localparam int STIM_CYCLES = FILL_N + DRAIN_N + MID_W + MID_N + RAND_N + 20;

   // Model state, one field per registered DUT output
   typedef struct packed {
      sync_fifo_ctrl_pkg::occ_t  occ;
      sync_fifo_ctrl_pkg::addr_t wptr;
      sync_fifo_ctrl_pkg::addr_t rptr;
      logic                      wack;
      logic [1:0]                dv;     // Data-valid delay line
      logic                      ovf;
      logic                      udf;
   } model_t;

   logic                      pos_clk;
   logic                      aresetn;
   logic                      we_i;
   logic                      re_i;
   sync_fifo_ctrl_pkg::occ_t  count_o;
   logic                      empty_o, aempty_o, full_o, afull_o;
   logic                      mem_we_o, mem_re_o;
   sync_fifo_ctrl_pkg::addr_t mem_waddr_o, mem_raddr_o;
   logic                      wack_o, dvld_o, overflow_o, underflow_o;

   int     errors = 0;
   int     checks = 0;
   int     ovf_seen = 0;   // Pulse tallies for the directed phases
   int     udf_seen = 0;
   int     dvld_seen = 0;
   model_t st;

   sync_fifo_ctrl i_dut (
      .pos_clk (pos_clk), .aresetn (aresetn), .we_i (we_i), .re_i (re_i),
      .count_o (count_o), .empty_o (empty_o), .aempty_o (aempty_o),
      .full_o (full_o), .afull_o (afull_o), .mem_we_o (mem_we_o), .mem_re_o (mem_re_o),
      .mem_waddr_o (mem_waddr_o), .mem_raddr_o (mem_raddr_o), .wack_o (wack_o),
      .dvld_o (dvld_o), .overflow_o (overflow_o), .underflow_o (underflow_o)
   );

   // ----------------------------------------------------------
   // Reference model and compare
   // ----------------------------------------------------------
   function automatic model_t ref_next(input model_t s, input logic we, input logic re);
      model_t n;
      logic   full;
      logic   empty;
      logic   wa;
      logic   ra;
      full  = (s.occ == `SFC_DEPTH);
      empty = (s.occ == 0);
      wa    = we && !full;                 // Accept rule
      ra    = re && !empty;
      n     = s;
      if (wa && !ra) n.occ = sync_fifo_ctrl_pkg::occ_t'(s.occ + 1);
      else if (ra && !wa) n.occ = sync_fifo_ctrl_pkg::occ_t'(s.occ - 1);
      if (wa) n.wptr = sync_fifo_ctrl_pkg::addr_t'((int'(s.wptr) + 1) % `SFC_DEPTH);
      if (ra) n.rptr = sync_fifo_ctrl_pkg::addr_t'((int'(s.rptr) + 1) % `SFC_DEPTH);
      n.wack = wa;
      n.dv   = {s.dv[0], ra};               // Shift in this read
      n.ovf  = we && full;                  // Refused write
      n.udf  = re && empty;                 // Refused read
      return n;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s: got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // ----------------------------------------------------------
   // Clock, stimulus helpers, watchdog
   // ----------------------------------------------------------
   initial begin
      pos_clk = 1'b0;
      forever #4 pos_clk = ~pos_clk;   // Period 8
   end

   task automatic drive_cycle(input logic we, input logic re);
      @(posedge pos_clk);
      #1;                                // Clear of the edge
      we_i = we;
      re_i = re;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0);
   endtask

   initial begin
      #((STIM_CYCLES + 50) * 8);
      $display("ERROR: timeout, stimulus did not complete within %0d cycles", STIM_CYCLES + 50);
      $display("STATUS: FAIL");
      $finish;
   end

   // Samples just before each rising edge, then steps the model
   initial begin
      logic exp_dvld;
      st = '0;                           // Reset state of the model
      forever begin
         @(posedge pos_clk);
         #7;
         exp_dvld = (`SFC_DVLD_LAT == 1) ? st.dv[0] : st.dv[1];
         check_val("count_o", count_o, st.occ);
         check_val("empty_o", empty_o, st.occ == 0);
         check_val("aempty_o", aempty_o, st.occ <= `SFC_AEMPTY_VAL);
         check_val("full_o", full_o, st.occ == `SFC_DEPTH);
         check_val("afull_o", afull_o, st.occ >= `SFC_AFULL_VAL);
         check_val("mem_we_o", mem_we_o, we_i && (st.occ != `SFC_DEPTH));
         check_val("mem_re_o", mem_re_o, re_i && (st.occ != 0));
         check_val("mem_waddr_o", mem_waddr_o, st.wptr);
         check_val("mem_raddr_o", mem_raddr_o, st.rptr);
         check_val("wack_o", wack_o, st.wack);
         check_val("dvld_o", dvld_o, exp_dvld);
         check_val("overflow_o", overflow_o, st.ovf);
         check_val("underflow_o", underflow_o, st.udf);
         if (overflow_o) ovf_seen++;
         if (underflow_o) udf_seen++;
         if (dvld_o) dvld_seen++;
         if (aresetn) begin
            st = ref_next(st, we_i, re_i);
         end else begin
            st = '0;                     // Edges under reset change nothing
         end
      end
   end

   // ----------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------
   initial begin
      int unsigned r;
      logic        fill;
      r       = $urandom(32'h462b14fe);  // Seed once
      aresetn = 1'b0;
      we_i    = 1'b0;
      re_i    = 1'b0;
      repeat (2) @(posedge pos_clk);
      #1 aresetn = 1'b1;
      idle_cycles(1);                    // First quiet edge out of reset
      repeat (FILL_N) drive_cycle(1'b1, 1'b0);
      idle_cycles(3);
      check_val("count after fill", count_o, `SFC_DEPTH);
      check_val("overflows in fill", ovf_seen, FILL_N - `SFC_DEPTH);
      repeat (DRAIN_N) drive_cycle(1'b0, 1'b1);
      idle_cycles(3);
      check_val("count after drain", count_o, 0);
      check_val("underflows in drain", udf_seen, DRAIN_N - `SFC_DEPTH);
      check_val("dvld pulses in drain", dvld_seen, `SFC_DEPTH);
      repeat (MID_W) drive_cycle(1'b1, 1'b0);
      repeat (MID_N) drive_cycle(1'b1, 1'b1);   // Pointers wrap, level holds
      idle_cycles(3);
      check_val("count after mixed", count_o, MID_W);
      check_val("waddr after mixed", mem_waddr_o, (MID_W + MID_N) % `SFC_DEPTH);
      check_val("raddr after mixed", mem_raddr_o, MID_N % `SFC_DEPTH);
      for (int i = 0; i < RAND_N; i++) begin
         fill = ((i / 250) % 2) == 0;    // Alternate fill and drain bias
         r    = $urandom;
         if (fill) drive_cycle((r % 4) != 0, ((r >> 2) % 4) == 0);
         else drive_cycle((r % 4) == 0, ((r >> 2) % 4) != 0);
      end
      idle_cycles(4);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) $display("STATUS: PASS");
      else $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
